// File: logic/local_ram.sv
`timescale 1ns/100ps

// word-wide scratch memory for the processor
// single port, read data one cycle after the address
module local_ram #(
	parameter int LR_ADDR_W = ppu_bus_pkg::LR_ADDR_W_DEF
) (
	input  logic                  core_sp_clk,
	input  logic [LR_ADDR_W-1:0]  lr_addr,
	input  logic                  lr_we,
	input  ppu_bus_pkg::word_t    lr_wdata,
	output ppu_bus_pkg::word_t    lr_rdata
);

	localparam int DEPTH = 2 ** LR_ADDR_W;

	ppu_bus_pkg::word_t mem [DEPTH];

	// read before write on the same address
	always_ff @(posedge core_sp_clk) begin
		if (lr_we) begin
			mem[lr_addr] <= lr_wdata;
		end
		lr_rdata <= mem[lr_addr];
	end

endmodule

// File: logic/pkt_buffer.sv
`timescale 1ns/100ps

// one packet memory with its length and life-cycle state
// filled by ingress, rewritten by the processor, drained by egress
module pkt_buffer #(
	parameter int BUF_ADDR_W = ppu_pkt_pkg::BUF_ADDR_W_DEF
) (
	input  logic                   core_sp_clk,
	input  logic                   reset,
	input  logic                   buf_wr,
	input  ppu_bus_pkg::word_t     buf_wdata,
	input  logic                   buf_wlast,
	output logic                   buf_empty,
	output logic                   buf_ready,
	output logic                   buf_draining,
	output ppu_pkt_pkg::pkt_len_t  buf_len,
	input  logic [BUF_ADDR_W-1:0]  pm_addr,
	input  logic                   pm_we,
	input  ppu_bus_pkg::word_t     pm_wdata,
	output ppu_bus_pkg::word_t     pm_rdata,
	input  logic                   pm_len_wr,
	input  ppu_pkt_pkg::pkt_len_t  pm_len,
	input  logic                   pm_done,
	input  logic [BUF_ADDR_W-1:0]  eg_addr,
	output ppu_bus_pkg::word_t     eg_rdata,
	input  logic                   eg_release
);

	localparam int DEPTH = 2 ** BUF_ADDR_W;

	ppu_bus_pkg::word_t       mem [DEPTH];
	ppu_pkt_pkg::buf_state_e  state;
	logic [BUF_ADDR_W-1:0]    wr_ptr;
	ppu_pkt_pkg::pkt_len_t    len;
	logic                     pm_wr_ok;

	// processor writes land only while it owns a ready packet
	assign pm_wr_ok = pm_we && (state == ppu_pkt_pkg::BUF_READY);

	// fill and rewrite never overlap, so they share the write port
	always_ff @(posedge core_sp_clk) begin
		if (buf_wr) begin
			mem[wr_ptr] <= buf_wdata;
		end else if (pm_wr_ok) begin
			mem[pm_addr] <= pm_wdata;
		end
	end

	// registered read ports, processor and egress
	always_ff @(posedge core_sp_clk) begin
		pm_rdata <= mem[pm_addr];
		eg_rdata <= mem[eg_addr];
	end

	always_ff @(posedge core_sp_clk) begin
		if (reset) begin
			state <= ppu_pkt_pkg::BUF_EMPTY;
			wr_ptr <= '0;
			len <= '0;
		end else begin
			case (state)
				ppu_pkt_pkg::BUF_EMPTY, ppu_pkt_pkg::BUF_FILLING: begin
					if (buf_wr) begin
						wr_ptr <= wr_ptr + 1'b1;
						len <= len + 1'b1;
						state <= buf_wlast ? ppu_pkt_pkg::BUF_READY : ppu_pkt_pkg::BUF_FILLING;
					end
				end
				ppu_pkt_pkg::BUF_READY: begin
					// length override from the processor
					if (pm_len_wr) begin
						len <= pm_len;
					end
					if (pm_done) begin
						state <= ppu_pkt_pkg::BUF_DRAINING;
					end
				end
				ppu_pkt_pkg::BUF_DRAINING: begin
					if (eg_release) begin
						state <= ppu_pkt_pkg::BUF_EMPTY;
						wr_ptr <= '0;
						len <= '0;
					end
				end
				default: state <= ppu_pkt_pkg::BUF_EMPTY;
			endcase
		end
	end

	assign buf_empty = (state == ppu_pkt_pkg::BUF_EMPTY);
	assign buf_ready = (state == ppu_pkt_pkg::BUF_READY);
	assign buf_draining = (state == ppu_pkt_pkg::BUF_DRAINING);
	assign buf_len = len;

endmodule

// File: logic/pkt_egress.sv
`timescale 1ns/100ps

// streams each finished buffer to the output port in turn
// honours sink back-pressure and releases the buffer after its last word
module pkt_egress #(
	parameter int NUM_BUF    = ppu_pkt_pkg::NUM_BUF_DEF,
	parameter int BUF_ADDR_W = ppu_pkt_pkg::BUF_ADDR_W_DEF
) (
	input  logic                   core_sp_clk,
	input  logic                   reset,
	input  logic [NUM_BUF-1:0]     buf_draining,
	input  ppu_pkt_pkg::pkt_len_t  buf_len [NUM_BUF],
	input  ppu_bus_pkg::word_t     eg_rdata [NUM_BUF],
	output logic [BUF_ADDR_W-1:0]  eg_addr,
	output logic [NUM_BUF-1:0]     eg_release,
	output ppu_bus_pkg::word_t     out_data,
	output logic                   out_req,
	output logic                   out_wr,
	output logic                   out_bop,
	output logic                   out_eop,
	input  logic                   out_ack,
	input  logic                   out_rdy
);

	localparam int SEL_W = (NUM_BUF > 1) ? $clog2(NUM_BUF) : 1;

	ppu_pkt_pkg::egress_state_e  state;
	logic [SEL_W-1:0]            cur;
	logic [SEL_W-1:0]            cur_plus_1;
	ppu_pkt_pkg::pkt_len_t       len;
	ppu_pkt_pkg::pkt_len_t       rd_ptr;
	ppu_pkt_pkg::pkt_len_t       sent_cnt;
	logic                        rd_pend;
	logic                        hold_valid;
	logic                        hold_valid_next;
	ppu_bus_pkg::word_t          hold_data;
	logic                        issue;

	assign len = buf_len[cur];
	assign cur_plus_1 = (cur == SEL_W'(NUM_BUF - 1)) ? '0 : cur + 1'b1;
	assign eg_addr = rd_ptr[BUF_ADDR_W-1:0];

	assign out_req = (state == ppu_pkt_pkg::EG_OFFER);
	// held word goes out before the word just read from memory
	assign out_data = hold_valid ? hold_data : eg_rdata[cur];
	assign out_wr = (state == ppu_pkt_pkg::EG_SEND) && (hold_valid || rd_pend) && out_rdy;
	assign out_bop = out_wr && (sent_cnt == '0);
	assign out_eop = out_wr && (sent_cnt == len - 1'b1);
	assign eg_release = out_eop ? (NUM_BUF'(1) << cur) : '0;

	// a read in flight always finds the holding register empty
	always_comb begin
		if (hold_valid) begin
			hold_valid_next = !out_rdy;
		end else begin
			hold_valid_next = rd_pend && !out_rdy;
		end
	end

	// a new read only when its word is sure to find room next cycle
	assign issue = (state == ppu_pkt_pkg::EG_SEND) && (rd_ptr < len) && !hold_valid_next;

	always_ff @(posedge core_sp_clk) begin
		if (reset) begin
			state <= ppu_pkt_pkg::EG_IDLE;
			cur <= '0;
			rd_ptr <= '0;
			sent_cnt <= '0;
			rd_pend <= 1'b0;
			hold_valid <= 1'b0;
		end else begin
			rd_pend <= issue;
			hold_valid <= hold_valid_next;
			if (issue) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			if (out_wr) begin
				sent_cnt <= sent_cnt + 1'b1;
			end
			case (state)
				ppu_pkt_pkg::EG_IDLE: begin
					if (buf_draining[cur]) begin
						state <= ppu_pkt_pkg::EG_OFFER;
					end else begin
						cur <= cur_plus_1;
					end
				end
				ppu_pkt_pkg::EG_OFFER: begin
					if (out_ack) begin
						state <= ppu_pkt_pkg::EG_SEND;
						rd_ptr <= '0;
						sent_cnt <= '0;
					end
				end
				ppu_pkt_pkg::EG_SEND: begin
					if (out_eop) begin
						state <= ppu_pkt_pkg::EG_IDLE;
						cur <= cur_plus_1;
					end
				end
				default: state <= ppu_pkt_pkg::EG_IDLE;
			endcase
		end
	end

	// capture the memory word when the sink cannot take it now
	always_ff @(posedge core_sp_clk) begin
		if (rd_pend && !out_rdy) begin
			hold_data <= eg_rdata[cur];
		end
	end

endmodule

// File: logic/pkt_ingress.sv
`timescale 1ns/100ps

// input side, claims the lowest empty buffer for each packet
// and steers the incoming words into it until the last one
module pkt_ingress #(
	parameter int NUM_BUF = ppu_pkt_pkg::NUM_BUF_DEF
) (
	input  logic                core_sp_clk,
	input  logic                reset,
	input  ppu_bus_pkg::word_t  in_data,
	input  logic                in_req,
	input  logic                in_wr,
	input  logic                in_last,
	output logic                in_ack,
	input  logic [NUM_BUF-1:0]  buf_empty,
	output logic [NUM_BUF-1:0]  buf_wr,
	output ppu_bus_pkg::word_t  buf_wdata,
	output logic                buf_wlast
);

	logic [NUM_BUF-1:0] sel;
	logic [NUM_BUF-1:0] first_empty;

	// lowest set bit of the empty vector
	assign first_empty = buf_empty & (~buf_empty + NUM_BUF'(1));

	always_ff @(posedge core_sp_clk) begin
		if (reset) begin
			in_ack <= 1'b0;
			sel <= '0;
		end else if (!in_ack) begin
			// no empty buffer means the request just waits
			if (in_req && |buf_empty) begin
				in_ack <= 1'b1;
				sel <= first_empty;
			end
		end else if (in_wr && in_last) begin
			in_ack <= 1'b0;
		end
	end

	// words only go out while the packet is accepted
	assign buf_wr = (in_ack && in_wr) ? sel : '0;
	assign buf_wdata = in_data;
	assign buf_wlast = in_last;

endmodule

// File: logic/pkt_proc_unit.sv
`timescale 1ns/100ps

// packet processing unit top level
// packets enter on the input port, are handed to the processor bus and leave on the output port
module pkt_proc_unit #(
	parameter int NUM_BUF    = ppu_pkt_pkg::NUM_BUF_DEF,
	parameter int BUF_ADDR_W = ppu_pkt_pkg::BUF_ADDR_W_DEF,
	parameter int LR_ADDR_W  = ppu_bus_pkg::LR_ADDR_W_DEF
) (
	input  logic                   core_sp_clk,
	input  logic                   reset,
	input  ppu_bus_pkg::word_t     in_data,
	input  logic                   in_req,
	input  logic                   in_wr,
	input  logic                   in_last,
	output logic                   in_ack,
	input  ppu_bus_pkg::sp_addr_t  sp_addr,
	input  ppu_bus_pkg::word_t     sp_wdata,
	input  logic                   sp_we,
	input  logic                   sp_stb,
	output ppu_bus_pkg::word_t     sp_rdata,
	output logic                   sp_grant,
	output ppu_bus_pkg::word_t     out_data,
	output logic                   out_req,
	output logic                   out_wr,
	output logic                   out_bop,
	output logic                   out_eop,
	input  logic                   out_ack,
	input  logic                   out_rdy
);

	// ingress to buffers
	logic [NUM_BUF-1:0]     buf_wr;
	ppu_bus_pkg::word_t     buf_wdata;
	logic                   buf_wlast;
	logic [NUM_BUF-1:0]     buf_empty;
	logic [NUM_BUF-1:0]     buf_ready;
	logic [NUM_BUF-1:0]     buf_draining;
	ppu_pkt_pkg::pkt_len_t  buf_len [NUM_BUF];

	// processor side of the buffers
	logic [BUF_ADDR_W-1:0]  pm_addr;
	logic [NUM_BUF-1:0]     pm_we;
	ppu_bus_pkg::word_t     pm_wdata;
	ppu_bus_pkg::word_t     pm_rdata [NUM_BUF];
	logic [NUM_BUF-1:0]     pm_len_wr;
	ppu_pkt_pkg::pkt_len_t  pm_len;
	logic [NUM_BUF-1:0]     pm_done;

	// egress side of the buffers
	logic [BUF_ADDR_W-1:0]  eg_addr;
	ppu_bus_pkg::word_t     eg_rdata [NUM_BUF];
	logic [NUM_BUF-1:0]     eg_release;

	// scratch memory
	logic [LR_ADDR_W-1:0]   lr_addr;
	logic                   lr_we;
	ppu_bus_pkg::word_t     lr_wdata;
	ppu_bus_pkg::word_t     lr_rdata;

	pkt_ingress #(
		.NUM_BUF (NUM_BUF)
	) u_ingress (
		.core_sp_clk (core_sp_clk),
		.reset       (reset),
		.in_data     (in_data),
		.in_req      (in_req),
		.in_wr       (in_wr),
		.in_last     (in_last),
		.in_ack      (in_ack),
		.buf_empty   (buf_empty),
		.buf_wr      (buf_wr),
		.buf_wdata   (buf_wdata),
		.buf_wlast   (buf_wlast)
	);

	for (genvar i = 0; i < NUM_BUF; i++) begin : g_buf
		pkt_buffer #(
			.BUF_ADDR_W (BUF_ADDR_W)
		) u_buf (
			.core_sp_clk  (core_sp_clk),
			.reset        (reset),
			.buf_wr       (buf_wr[i]),
			.buf_wdata    (buf_wdata),
			.buf_wlast    (buf_wlast),
			.buf_empty    (buf_empty[i]),
			.buf_ready    (buf_ready[i]),
			.buf_draining (buf_draining[i]),
			.buf_len      (buf_len[i]),
			.pm_addr      (pm_addr),
			.pm_we        (pm_we[i]),
			.pm_wdata     (pm_wdata),
			.pm_rdata     (pm_rdata[i]),
			.pm_len_wr    (pm_len_wr[i]),
			.pm_len       (pm_len),
			.pm_done      (pm_done[i]),
			.eg_addr      (eg_addr),
			.eg_rdata     (eg_rdata[i]),
			.eg_release   (eg_release[i])
		);
	end

	sp_bus_arbiter #(
		.NUM_BUF    (NUM_BUF),
		.BUF_ADDR_W (BUF_ADDR_W),
		.LR_ADDR_W  (LR_ADDR_W)
	) u_arbiter (
		.core_sp_clk (core_sp_clk),
		.reset       (reset),
		.sp_addr     (sp_addr),
		.sp_wdata    (sp_wdata),
		.sp_we       (sp_we),
		.sp_stb      (sp_stb),
		.sp_rdata    (sp_rdata),
		.sp_grant    (sp_grant),
		.buf_ready   (buf_ready),
		.pm_rdata    (pm_rdata),
		.pm_addr     (pm_addr),
		.pm_we       (pm_we),
		.pm_wdata    (pm_wdata),
		.pm_len_wr   (pm_len_wr),
		.pm_len      (pm_len),
		.pm_done     (pm_done),
		.lr_addr     (lr_addr),
		.lr_we       (lr_we),
		.lr_wdata    (lr_wdata),
		.lr_rdata    (lr_rdata)
	);

	local_ram #(
		.LR_ADDR_W (LR_ADDR_W)
	) u_local_ram (
		.core_sp_clk (core_sp_clk),
		.lr_addr     (lr_addr),
		.lr_we       (lr_we),
		.lr_wdata    (lr_wdata),
		.lr_rdata    (lr_rdata)
	);

	pkt_egress #(
		.NUM_BUF    (NUM_BUF),
		.BUF_ADDR_W (BUF_ADDR_W)
	) u_egress (
		.core_sp_clk  (core_sp_clk),
		.reset        (reset),
		.buf_draining (buf_draining),
		.buf_len      (buf_len),
		.eg_rdata     (eg_rdata),
		.eg_addr      (eg_addr),
		.eg_release   (eg_release),
		.out_data     (out_data),
		.out_req      (out_req),
		.out_wr       (out_wr),
		.out_bop      (out_bop),
		.out_eop      (out_eop),
		.out_ack      (out_ack),
		.out_rdy      (out_rdy)
	);

endmodule

// File: logic/ppu_bus_pkg.sv
// service-processor bus definitions shared by the arbiter, the local RAM and the top level
// covers word and address widths, the address region decode and the arbiter states
package ppu_bus_pkg;

	// one data word on the bus and in every memory
	typedef logic [31:0] word_t;

	// processor byte address
	typedef logic [31:0] sp_addr_t;

	// region code, taken from the upper address bits
	typedef logic [2:0] region_t;

	localparam int REGION_MSB = 30;
	localparam int REGION_LSB = 28;

	// address map
	localparam region_t REGION_LOCAL_RAM = 3'd0;
	localparam region_t REGION_PKT_MEM   = 3'd1;
	localparam region_t REGION_PKT_DONE  = 3'd2;
	localparam region_t REGION_PKT_LEN   = 3'd3;

	// 256 words of scratch memory by default
	localparam int LR_ADDR_W_DEF = 8;

	// bus ownership
	typedef enum logic {
		SP_IDLE = 1'b0,
		SP_PROC = 1'b1
	} sp_state_e;

endpackage

// File: logic/ppu_pkt_pkg.sv
// packet-side definitions shared by ingress, the packet buffers and egress
// covers the length type, buffer sizing defaults and the buffer and egress states
package ppu_pkt_pkg;

	// packet length in words
	typedef logic [7:0] pkt_len_t;

	// number of packet buffers
	localparam int NUM_BUF_DEF = 4;

	// 64 words per buffer
	localparam int BUF_ADDR_W_DEF = 6;

	// life cycle of one buffer
	typedef enum logic [1:0] {
		BUF_EMPTY    = 2'd0,
		BUF_FILLING  = 2'd1,
		BUF_READY    = 2'd2,
		BUF_DRAINING = 2'd3
	} buf_state_e;

	// output side
	typedef enum logic [1:0] {
		EG_IDLE  = 2'd0,
		EG_OFFER = 2'd1,
		EG_SEND  = 2'd2
	} egress_state_e;

endpackage

// File: logic/sp_bus_arbiter.sv
`timescale 1ns/100ps

// hands the processor bus to one ready buffer at a time, round robin
// and decodes each bus strobe into packet memory, length, done or local RAM access
module sp_bus_arbiter #(
	parameter int NUM_BUF    = ppu_pkt_pkg::NUM_BUF_DEF,
	parameter int BUF_ADDR_W = ppu_pkt_pkg::BUF_ADDR_W_DEF,
	parameter int LR_ADDR_W  = ppu_bus_pkg::LR_ADDR_W_DEF
) (
	input  logic                   core_sp_clk,
	input  logic                   reset,
	input  ppu_bus_pkg::sp_addr_t  sp_addr,
	input  ppu_bus_pkg::word_t     sp_wdata,
	input  logic                   sp_we,
	input  logic                   sp_stb,
	output ppu_bus_pkg::word_t     sp_rdata,
	output logic                   sp_grant,
	input  logic [NUM_BUF-1:0]     buf_ready,
	input  ppu_bus_pkg::word_t     pm_rdata [NUM_BUF],
	output logic [BUF_ADDR_W-1:0]  pm_addr,
	output logic [NUM_BUF-1:0]     pm_we,
	output ppu_bus_pkg::word_t     pm_wdata,
	output logic [NUM_BUF-1:0]     pm_len_wr,
	output ppu_pkt_pkg::pkt_len_t  pm_len,
	output logic [NUM_BUF-1:0]     pm_done,
	output logic [LR_ADDR_W-1:0]   lr_addr,
	output logic                   lr_we,
	output ppu_bus_pkg::word_t     lr_wdata,
	input  ppu_bus_pkg::word_t     lr_rdata
);

	localparam int SEL_W = (NUM_BUF > 1) ? $clog2(NUM_BUF) : 1;

	ppu_bus_pkg::sp_state_e  state;
	logic [SEL_W-1:0]        curr_buf;
	logic [SEL_W-1:0]        curr_buf_plus_1;
	logic [NUM_BUF-1:0]      curr_onehot;
	ppu_bus_pkg::region_t    region;
	logic                    acc_lr;
	logic                    acc_pm;
	logic                    acc_len;
	logic                    acc_done;
	logic                    rd_lr;
	logic                    rd_pm;

	assign region = sp_addr[ppu_bus_pkg::REGION_MSB:ppu_bus_pkg::REGION_LSB];
	assign curr_buf_plus_1 = (curr_buf == SEL_W'(NUM_BUF - 1)) ? '0 : curr_buf + 1'b1;
	assign curr_onehot = NUM_BUF'(1) << curr_buf;
	assign sp_grant = (state == ppu_bus_pkg::SP_PROC);

	// local RAM is always reachable, buffer regions need the grant
	assign acc_lr = sp_stb && (region == ppu_bus_pkg::REGION_LOCAL_RAM);
	assign acc_pm = sp_stb && sp_grant && (region == ppu_bus_pkg::REGION_PKT_MEM);
	assign acc_len = sp_stb && sp_grant && sp_we && (region == ppu_bus_pkg::REGION_PKT_LEN);
	assign acc_done = sp_stb && sp_grant && (region == ppu_bus_pkg::REGION_PKT_DONE);

	// byte address to word address
	assign pm_addr = sp_addr[BUF_ADDR_W+1:2];
	assign pm_wdata = sp_wdata;
	assign pm_len = sp_wdata[$bits(ppu_pkt_pkg::pkt_len_t)-1:0];
	assign pm_we = (acc_pm && sp_we) ? curr_onehot : '0;
	assign pm_len_wr = acc_len ? curr_onehot : '0;
	assign pm_done = acc_done ? curr_onehot : '0;

	assign lr_addr = sp_addr[LR_ADDR_W+1:2];
	assign lr_we = acc_lr && sp_we;
	assign lr_wdata = sp_wdata;

	// one buffer looked at per idle cycle
	always_ff @(posedge core_sp_clk) begin
		if (reset) begin
			state <= ppu_bus_pkg::SP_IDLE;
			curr_buf <= '0;
		end else begin
			case (state)
				ppu_bus_pkg::SP_IDLE: begin
					if (buf_ready[curr_buf]) begin
						state <= ppu_bus_pkg::SP_PROC;
					end else begin
						curr_buf <= curr_buf_plus_1;
					end
				end
				ppu_bus_pkg::SP_PROC: begin
					if (acc_done) begin
						state <= ppu_bus_pkg::SP_IDLE;
						curr_buf <= curr_buf_plus_1;
					end
				end
				default: state <= ppu_bus_pkg::SP_IDLE;
			endcase
		end
	end

	// remember which region a read went to
	always_ff @(posedge core_sp_clk) begin
		if (reset) begin
			rd_lr <= 1'b0;
			rd_pm <= 1'b0;
		end else begin
			rd_lr <= acc_lr && !sp_we;
			rd_pm <= acc_pm && !sp_we;
		end
	end

	// lines up with the registered memory outputs
	always_comb begin
		if (rd_lr) begin
			sp_rdata = lr_rdata;
		end else if (rd_pm) begin
			sp_rdata = pm_rdata[curr_buf];
		end else begin
			sp_rdata = '0;
		end
	end

endmodule

// File: verification/ppu_checker.sv
`timescale 1ns/100ps

// sink side of the testbench, acknowledges offered packets and collects the output words
// each finished packet is compared with the next expected packet from the queue
module ppu_checker (
	input  logic                core_sp_clk,
	input  logic                reset,
	input  ppu_bus_pkg::word_t  out_data,
	input  logic                out_req,
	input  logic                out_wr,
	input  logic                out_bop,
	input  logic                out_eop,
	input  logic                out_rdy,
	output logic                out_ack
);

	ppu_bus_pkg::word_t exp_words [$];
	int                 exp_lens [$];
	ppu_bus_pkg::word_t got [$];
	int                 err_count;
	int                 pkt_count;

	// expected packets arrive in the order of the done strobes
	task automatic add_expected(input ppu_bus_pkg::word_t pkt [$]);
		foreach (pkt[i]) begin
			exp_words.push_back(pkt[i]);
		end
		exp_lens.push_back(pkt.size());
	endtask

	function automatic int pending_packets();
		return exp_lens.size();
	endfunction

	task automatic log_mismatch(input string msg);
		err_count++;
		$display("CHECK FAILED at %0t ns: %s", $time, msg);
	endtask

	task automatic compare_packet();
		int n;
		ppu_bus_pkg::word_t w;
		pkt_count++;
		if (exp_lens.size() == 0) begin
			log_mismatch($sformatf("packet %0d came out with none expected", pkt_count));
			got.delete();
			return;
		end
		n = exp_lens.pop_front();
		if (got.size() != n) begin
			log_mismatch($sformatf("packet %0d has %0d words, expected %0d",
				pkt_count, got.size(), n));
		end
		for (int i = 0; i < n; i++) begin
			w = exp_words.pop_front();
			if (i < got.size() && got[i] != w) begin
				log_mismatch($sformatf("packet %0d word %0d is %h, expected %h",
					pkt_count, i, got[i], w));
			end
		end
		got.delete();
	endtask

	initial begin
		out_ack = 1'b0;
		err_count = 0;
		pkt_count = 0;
	end

	// one-cycle ack pulse once out_req is seen
	always @(negedge core_sp_clk) begin
		out_ack <= !reset && out_req && !out_ack;
	end

	// sampled at the edge where the DUT hands the word over
	always @(posedge core_sp_clk) begin
		if (!reset) begin
			if (out_wr && !out_rdy) begin
				log_mismatch("out_wr high while out_rdy is low");
			end
			if (out_wr) begin
				if (out_bop && got.size() != 0) begin
					log_mismatch("out_bop in the middle of a packet");
				end
				if (out_bop) begin
					got.delete();
				end else if (got.size() == 0) begin
					log_mismatch("first word of a packet without out_bop");
				end
				got.push_back(out_data);
				if (out_eop) begin
					compare_packet();
				end
			end
		end
	end

endmodule

// File: verification/ppu_tb.sv
`timescale 1ns/100ps

// testbench for the packet processing unit that plays the packet source and the processor
// output packets are checked by the checker instance against the reference function
module ppu_tb;

	localparam int NUM_BUF  = ppu_pkt_pkg::NUM_BUF_DEF;
	localparam int NUM_PKTS = NUM_BUF + 5;
	localparam int LR_WORDS = 2 ** ppu_bus_pkg::LR_ADDR_W_DEF;
	localparam ppu_bus_pkg::sp_addr_t PKT_MEM_BASE = 32'h1000_0000;
	localparam ppu_bus_pkg::sp_addr_t DONE_ADDR    = 32'h2000_0000;
	localparam ppu_bus_pkg::sp_addr_t LEN_ADDR     = 32'h3000_0000;

	typedef ppu_bus_pkg::word_t word_q_t [$];

	logic                   core_sp_clk;
	logic                   reset;
	ppu_bus_pkg::word_t     in_data;
	logic                   in_req;
	logic                   in_wr;
	logic                   in_last;
	logic                   in_ack;
	ppu_bus_pkg::sp_addr_t  sp_addr;
	ppu_bus_pkg::word_t     sp_wdata;
	logic                   sp_we;
	logic                   sp_stb;
	ppu_bus_pkg::word_t     sp_rdata;
	logic                   sp_grant;
	ppu_bus_pkg::word_t     out_data;
	logic                   out_req;
	logic                   out_wr;
	logic                   out_bop;
	logic                   out_eop;
	logic                   out_ack;
	logic                   out_rdy;

	word_q_t             sent_pkts [NUM_PKTS];
	ppu_bus_pkg::word_t  lr_model [LR_WORDS];
	int                  tb_errs;
	int                  cycle_count;
	int                  cycle_limit;
	bit                  rdy_random;

	pkt_proc_unit DUT (.*);

	ppu_checker u_checker (
		.core_sp_clk (core_sp_clk),
		.reset       (reset),
		.out_data    (out_data),
		.out_req     (out_req),
		.out_wr      (out_wr),
		.out_bop     (out_bop),
		.out_eop     (out_eop),
		.out_rdy     (out_rdy),
		.out_ack     (out_ack)
	);

	always #5 core_sp_clk = ~core_sp_clk;

	// sink ready is random only during the back-pressure test
	always @(negedge core_sp_clk) begin
		out_rdy <= rdy_random ? ($urandom_range(0, 1) != 0) : 1'b1;
	end

	always @(posedge core_sp_clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_limit != 0 && cycle_count >= cycle_limit) begin
			$display("timeout: the run was still busy after %0d cycles", cycle_count);
			$display("Done: errors found");
			$finish;
		end
	end

	// first new_len words of the packet XOR the key
	function automatic word_q_t expected_packet(word_q_t sent, ppu_bus_pkg::word_t key,
			int new_len);
		word_q_t res;
		for (int i = 0; i < new_len; i++) begin
			res.push_back(sent[i] ^ key);
		end
		return res;
	endfunction

	function automatic int total_errors();
		return tb_errs + u_checker.err_count;
	endfunction

	task automatic report_mismatch(input string msg);
		tb_errs++;
		$display("CHECK FAILED at %0t ns: %s", $time, msg);
	endtask

	task automatic bus_write(input ppu_bus_pkg::sp_addr_t addr, input ppu_bus_pkg::word_t data);
		@(negedge core_sp_clk);
		sp_addr = addr;
		sp_wdata = data;
		sp_we = 1'b1;
		sp_stb = 1'b1;
		@(negedge core_sp_clk);
		sp_stb = 1'b0;
		sp_we = 1'b0;
	endtask

	task automatic bus_read(input ppu_bus_pkg::sp_addr_t addr, output ppu_bus_pkg::word_t data);
		@(negedge core_sp_clk);
		sp_addr = addr;
		sp_we = 1'b0;
		sp_stb = 1'b1;
		@(negedge core_sp_clk);
		data = sp_rdata;
		sp_stb = 1'b0;
	endtask

	task automatic wait_in_ack();
		@(negedge core_sp_clk);
		in_req = 1'b1;
		while (!in_ack) begin
			@(negedge core_sp_clk);
		end
	endtask

	// one word per cycle starting in the cycle in_ack is seen
	task automatic stream_words(input int id);
		for (int i = 0; i < sent_pkts[id].size(); i++) begin
			in_data = sent_pkts[id][i];
			in_wr = 1'b1;
			in_last = (i == sent_pkts[id].size() - 1);
			@(negedge core_sp_clk);
		end
		in_wr = 1'b0;
		in_last = 1'b0;
		in_req = 1'b0;
	endtask

	task automatic send_packet(input int id);
		wait_in_ack();
		stream_words(id);
	endtask

	// processor work on one granted buffer whose first word names the packet
	task automatic process_packet(input ppu_bus_pkg::word_t key, input bit truncate);
		ppu_bus_pkg::word_t w;
		int id;
		int len;
		int new_len;
		do @(negedge core_sp_clk); while (!sp_grant);
		bus_read(PKT_MEM_BASE, w);
		id = w[15:0];
		if (w[31:16] != 16'hC0DE || id >= NUM_PKTS) begin
			tb_errs++;
			$display("granted buffer holds an unknown packet, first word %h", w);
			bus_write(DONE_ADDR, '0);
			return;
		end
		len = sent_pkts[id].size();
		new_len = truncate ? $urandom_range(1, len - 1) : len;
		for (int i = 1; i < len; i++) begin
			bus_read(PKT_MEM_BASE + 4 * i, w);
			if (w != sent_pkts[id][i]) begin
				report_mismatch($sformatf("packet %0d word %0d read as %h, sent %h",
					id, i, w, sent_pkts[id][i]));
			end
		end
		if (key != '0) begin
			for (int i = 0; i < len; i++) begin
				bus_write(PKT_MEM_BASE + 4 * i, sent_pkts[id][i] ^ key);
			end
		end
		if (new_len != len) begin
			bus_write(LEN_ADDR, new_len);
		end
		u_checker.add_expected(expected_packet(sent_pkts[id], key, new_len));
		bus_write(DONE_ADDR, '0);
	endtask

	// scratch RAM writes to random addresses and reads back against the model
	task automatic exercise_local_ram(input int count);
		int addrs [$];
		ppu_bus_pkg::word_t w;
		for (int i = 0; i < count; i++) begin
			addrs.push_back($urandom_range(0, LR_WORDS - 1));
			w = $urandom;
			lr_model[addrs[i]] = w;
			bus_write(4 * addrs[i], w);
		end
		foreach (addrs[i]) begin
			bus_read(4 * addrs[i], w);
			if (w != lr_model[addrs[i]]) begin
				report_mismatch($sformatf("local RAM word %0d read as %h, expected %h",
					addrs[i], w, lr_model[addrs[i]]));
			end
		end
	endtask

	task automatic wait_drained();
		do @(negedge core_sp_clk); while (u_checker.pending_packets() != 0);
	endtask

	task automatic log_test_result(input int num, input string name, input int errs_before);
		$display("test %0d (%s) finished with %0d errors", num, name,
			total_errors() - errs_before);
	endtask

	initial begin
		int seed_ret;
		int len;
		int errs_before;
		int count_before;
		core_sp_clk = 1'b0;
		reset = 1'b1;
		in_data = '0;
		in_req = 1'b0;
		in_wr = 1'b0;
		in_last = 1'b0;
		sp_addr = '0;
		sp_wdata = '0;
		sp_we = 1'b0;
		sp_stb = 1'b0;
		out_rdy = 1'b1;
		rdy_random = 1'b0;
		tb_errs = 0;
		cycle_count = 0;
		seed_ret = $urandom(32'h513b_1b63);

		// packet id sits in the low half of the first word
		cycle_limit = 0;
		for (int p = 0; p < NUM_PKTS; p++) begin
			len = $urandom_range(4, 32);
			sent_pkts[p].push_back(32'hC0DE_0000 | p);
			for (int i = 1; i < len; i++) begin
				sent_pkts[p].push_back($urandom);
			end
			cycle_limit += 4 * len + 200;
		end

		repeat (4) @(negedge core_sp_clk);
		if (in_ack || sp_grant || out_req || out_wr || out_bop || out_eop) begin
			report_mismatch("a handshake or output flag is high after reset");
		end
		reset = 1'b0;

		errs_before = total_errors();
		send_packet(0);
		process_packet('0, 1'b0);
		wait_drained();
		log_test_result(1, "pass-through", errs_before);

		errs_before = total_errors();
		send_packet(1);
		process_packet($urandom | 32'h100, 1'b1);
		wait_drained();
		log_test_result(2, "rewrite and truncate", errs_before);

		errs_before = total_errors();
		if (sp_grant) begin
			tb_errs++;
			$display("sp_grant is high with no packet waiting");
		end
		exercise_local_ram(8);
		send_packet(2);
		do @(negedge core_sp_clk); while (!sp_grant);
		exercise_local_ram(8);
		process_packet('0, 1'b0);
		wait_drained();
		log_test_result(3, "local RAM", errs_before);

		// with every buffer full the next packet has to wait for a free one
		errs_before = total_errors();
		for (int p = 3; p < 3 + NUM_BUF; p++) begin
			send_packet(p);
		end
		count_before = u_checker.pkt_count;
		fork
			begin
				wait_in_ack();
				if (u_checker.pkt_count == count_before) begin
					report_mismatch("in_ack given while every buffer was full");
				end
				stream_words(3 + NUM_BUF);
			end
			begin
				repeat (20) @(negedge core_sp_clk);
				process_packet('0, 1'b0);
			end
		join
		for (int i = 0; i < NUM_BUF; i++) begin
			process_packet($urandom | 32'h100, 1'b1);
		end
		wait_drained();
		log_test_result(4, "all buffers full", errs_before);

		errs_before = total_errors();
		rdy_random = 1'b1;
		send_packet(NUM_PKTS - 1);
		process_packet($urandom | 32'h100, 1'b1);
		wait_drained();
		rdy_random = 1'b0;
		log_test_result(5, "back-pressure", errs_before);

		$display("5 tests run, %0d packets checked, %0d errors", u_checker.pkt_count,
			total_errors());
		if (total_errors() == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule

// File: verilog.f
logic/ppu_bus_pkg.sv
logic/ppu_pkt_pkg.sv
logic/local_ram.sv
logic/pkt_buffer.sv
logic/pkt_ingress.sv
logic/sp_bus_arbiter.sv
logic/pkt_egress.sv
logic/pkt_proc_unit.sv
verification/ppu_checker.sv
verification/ppu_tb.sv
